// File: common/mem_stage_config.svh
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// data path width in bits
`define MEM_XLEN 64

// request address width, physical
`define MEM_ADDR_W 64

// data RAM depth in words
`define MEM_RAM_WORDS 256

// request queue depth, also the credits upstream holds after reset
`define MEM_REQ_DEPTH 4

// result credits granted by the consumer
`define MEM_RES_CREDITS 2

`endif

// File: common/mem_data_pkg.sv
`include "mem_stage_config.svh"

package mem_data_pkg;

  // one data word as held in the RAM
  typedef logic [`MEM_XLEN-1:0] word_t;

  typedef logic [`MEM_ADDR_W-1:0] addr_t;

  // byte lane inside a word
  typedef logic [$clog2(`MEM_XLEN/8)-1:0] byte_offset_t;

  // word address into the data RAM
  typedef logic [$clog2(`MEM_RAM_WORDS)-1:0] word_index_t;

  typedef logic [4:0] regno_t; // x0..x31

endpackage

// File: common/mem_op_pkg.sv
package mem_op_pkg;
  import mem_data_pkg::*;

  typedef enum logic [3:0] {
    OP_LB,
    OP_LBU,
    OP_LH,
    OP_LHU,
    OP_LW,
    OP_LWU,
    OP_LD,
    OP_SB,
    OP_SH,
    OP_SW,
    OP_SD
  } mem_op_t;

  typedef enum logic [1:0] {
    SZ_BYTE,
    SZ_HALF,
    SZ_WORD,
    SZ_DOUBLE
  } mem_size_t;

  // one request as it sits in the input queue
  typedef struct packed {
    mem_op_t op;
    addr_t   addr;
    word_t   wdata;
    regno_t  rd;
  } req_entry_t;

  function automatic mem_size_t op_size(mem_op_t op);
    case (op)
      OP_LB, OP_LBU, OP_SB: return SZ_BYTE;
      OP_LH, OP_LHU, OP_SH: return SZ_HALF;
      OP_LW, OP_LWU, OP_SW: return SZ_WORD;
      default:              return SZ_DOUBLE;
    endcase
  endfunction

  function automatic logic op_is_store(mem_op_t op);
    return op inside {OP_SB, OP_SH, OP_SW, OP_SD};
  endfunction

endpackage

// File: rtl/req_queue.sv
`include "mem_stage_config.svh"

module req_queue import mem_op_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       push,
  input  req_entry_t push_entry,
  input  logic       pop,
  output logic       not_empty,
  output req_entry_t head,
  output logic       credit
);

  localparam int DEPTH = `MEM_REQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  req_entry_t entries [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // upstream never pushes without a credit, so no full check here
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      credit <= pop; // one credit back per popped entry
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      entries[wr_ptr] <= push_entry;
  end

  assign not_empty = (count != '0);
  assign head      = entries[rd_ptr];

endmodule

// File: rtl/mem_issue.sv
`include "mem_stage_config.svh"

module mem_issue import mem_op_pkg::*, mem_data_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         not_empty,
  input  req_entry_t   head,
  output logic         pop,
  input  logic         res_credit,
  output word_index_t  rd_index,
  output logic         s1_valid,
  output mem_op_t      s1_op,
  output byte_offset_t s1_offset,
  output word_t        s1_wdata,
  output regno_t       s1_rd
);

  localparam int CRED_W = $clog2(`MEM_RES_CREDITS + 1);
  localparam int OFS_W  = $bits(byte_offset_t);

  logic [CRED_W-1:0] credits;
  byte_offset_t      offset_mask;

  // issue only with a result slot reserved downstream
  assign pop = not_empty && (credits != '0);

  // the RAM registers this index on the pop edge
  assign rd_index = head.addr[OFS_W +: $bits(word_index_t)];

  // misaligned low bits are dropped, not trapped
  always_comb begin
    case (op_size(head.op))
      SZ_BYTE: offset_mask = 3'b111;
      SZ_HALF: offset_mask = 3'b110;
      SZ_WORD: offset_mask = 3'b100;
      default: offset_mask = 3'b000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      credits  <= CRED_W'(`MEM_RES_CREDITS);
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= pop;
      case ({pop, res_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits; // both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    s1_op     <= head.op;
    s1_offset <= head.addr[OFS_W-1:0] & offset_mask;
    s1_wdata  <= head.wdata;
    s1_rd     <= head.rd;
  end

endmodule

// File: dmem/data_ram.sv
`include "mem_stage_config.svh"

module data_ram import mem_data_pkg::*; (
  input  logic        clk,
  input  word_index_t rd_index,
  output word_t       rd_word,
  input  logic        we,
  input  word_index_t wr_index,
  input  word_t       wr_word
);

  word_t mem [`MEM_RAM_WORDS];

  always_ff @(posedge clk) begin
    if (we)
      mem[wr_index] <= wr_word;
  end

  // write-first: a read of the word being written sees the new value
  always_ff @(posedge clk) begin
    if (we && (wr_index == rd_index))
      rd_word <= wr_word;
    else
      rd_word <= mem[rd_index];
  end

endmodule

// File: dmem/store_merge.sv
module store_merge import mem_op_pkg::*, mem_data_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         s1_valid,
  input  mem_op_t      s1_op,
  input  byte_offset_t s1_offset,
  input  word_t        s1_wdata,
  input  regno_t       s1_rd,
  input  word_index_t  rd_index,
  input  word_t        rd_word,
  output logic         we,
  output word_index_t  wr_index,
  output word_t        wr_word,
  output logic         s2_valid,
  output mem_op_t      s2_op,
  output byte_offset_t s2_offset,
  output word_t        s2_word,
  output regno_t       s2_rd
);

  localparam int BYTES = $bits(word_t) / 8;

  logic [BYTES-1:0] byte_en;
  word_t            shifted_wdata;

  // read-modify-write of the word fetched on the pop edge
  always_comb begin
    case (op_size(s1_op))
      SZ_BYTE: byte_en = BYTES'(8'h01) << s1_offset;
      SZ_HALF: byte_en = BYTES'(8'h03) << s1_offset;
      SZ_WORD: byte_en = BYTES'(8'h0f) << s1_offset;
      default: byte_en = '1; // sd overwrites the lot
    endcase
    shifted_wdata = s1_wdata << {s1_offset, 3'b000};
    for (int i = 0; i < BYTES; i++) begin
      wr_word[8*i +: 8] = byte_en[i] ? shifted_wdata[8*i +: 8] : rd_word[8*i +: 8];
    end
  end

  assign we = s1_valid && op_is_store(s1_op);

  always_ff @(posedge clk) begin
    wr_index <= rd_index; // index of the word now on rd_word
  end

  always_ff @(posedge clk) begin
    if (reset)
      s2_valid <= 1'b0;
    else
      s2_valid <= s1_valid;
  end

  always_ff @(posedge clk) begin
    s2_op     <= s1_op;
    s2_offset <= s1_offset;
    s2_word   <= rd_word;
    s2_rd     <= s1_rd;
  end

endmodule

// File: rtl/load_align.sv
module load_align import mem_op_pkg::*, mem_data_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         s2_valid,
  input  mem_op_t      s2_op,
  input  byte_offset_t s2_offset,
  input  word_t        s2_word,
  input  regno_t       s2_rd,
  output logic         res_valid,
  output word_t        res_data,
  output regno_t       res_rd,
  output logic         res_wen
);

  localparam int XW = $bits(word_t);

  word_t field;
  word_t ext_data;
  logic  is_store;

  assign is_store = op_is_store(s2_op);

  always_comb begin
    field = s2_word >> {s2_offset, 3'b000}; // wanted lane down to bit 0
    case (s2_op)
      OP_LB:   ext_data = {{(XW-8){field[7]}}, field[7:0]};
      OP_LBU:  ext_data = word_t'(field[7:0]);
      OP_LH:   ext_data = {{(XW-16){field[15]}}, field[15:0]};
      OP_LHU:  ext_data = word_t'(field[15:0]);
      OP_LW:   ext_data = {{(XW-32){field[31]}}, field[31:0]};
      OP_LWU:  ext_data = word_t'(field[31:0]);
      OP_LD:   ext_data = field;
      default: ext_data = '0; // stores carry no data back
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
      res_wen   <= 1'b0;
    end else begin
      res_valid <= s2_valid;
      res_wen   <= s2_valid && !is_store; // loads update rd
    end
  end

  always_ff @(posedge clk) begin
    res_data <= ext_data;
    res_rd   <= s2_rd;
  end

endmodule

// File: rtl/mem_stage_top.sv
module mem_stage_top import mem_op_pkg::*, mem_data_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    req_valid,
  input  mem_op_t req_op,
  input  addr_t   req_addr,
  input  word_t   req_wdata,
  input  regno_t  req_rd,
  output logic    req_credit,
  output logic    res_valid,
  output word_t   res_data,
  output regno_t  res_rd,
  output logic    res_wen,
  input  logic    res_credit
);

  req_entry_t   push_entry;
  req_entry_t   head;
  logic         not_empty;
  logic         pop;

  word_index_t  rd_index;
  word_t        rd_word;
  logic         we;
  word_index_t  wr_index;
  word_t        wr_word;

  logic         s1_valid;
  mem_op_t      s1_op;
  byte_offset_t s1_offset;
  word_t        s1_wdata;
  regno_t       s1_rd;

  logic         s2_valid;
  mem_op_t      s2_op;
  byte_offset_t s2_offset;
  word_t        s2_word;
  regno_t       s2_rd;

  assign push_entry = '{op: req_op, addr: req_addr, wdata: req_wdata, rd: req_rd};

  req_queue u_req_queue (
    .clk        (clk),
    .reset      (reset),
    .push       (req_valid),
    .push_entry (push_entry),
    .pop        (pop),
    .not_empty  (not_empty),
    .head       (head),
    .credit     (req_credit)
  );

  mem_issue u_mem_issue (
    .clk        (clk),
    .reset      (reset),
    .not_empty  (not_empty),
    .head       (head),
    .pop        (pop),
    .res_credit (res_credit),
    .rd_index   (rd_index),
    .s1_valid   (s1_valid),
    .s1_op      (s1_op),
    .s1_offset  (s1_offset),
    .s1_wdata   (s1_wdata),
    .s1_rd      (s1_rd)
  );

  data_ram u_data_ram (
    .clk      (clk),
    .rd_index (rd_index),
    .rd_word  (rd_word),
    .we       (we),
    .wr_index (wr_index),
    .wr_word  (wr_word)
  );

  store_merge u_store_merge (
    .clk       (clk),
    .reset     (reset),
    .s1_valid  (s1_valid),
    .s1_op     (s1_op),
    .s1_offset (s1_offset),
    .s1_wdata  (s1_wdata),
    .s1_rd     (s1_rd),
    .rd_index  (rd_index),
    .rd_word   (rd_word),
    .we        (we),
    .wr_index  (wr_index),
    .wr_word   (wr_word),
    .s2_valid  (s2_valid),
    .s2_op     (s2_op),
    .s2_offset (s2_offset),
    .s2_word   (s2_word),
    .s2_rd     (s2_rd)
  );

  load_align u_load_align (
    .clk       (clk),
    .reset     (reset),
    .s2_valid  (s2_valid),
    .s2_op     (s2_op),
    .s2_offset (s2_offset),
    .s2_word   (s2_word),
    .s2_rd     (s2_rd),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_rd    (res_rd),
    .res_wen   (res_wen)
  );

endmodule

// File: bench/mem_stage_tb.sv
`include "mem_stage_config.svh"

module mem_stage_tb import mem_op_pkg::*, mem_data_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  logic    clk;
  logic    reset;
  logic    req_valid;
  mem_op_t req_op;
  addr_t   req_addr;
  word_t   req_wdata;
  regno_t  req_rd;
  logic    req_credit;
  logic    res_valid;
  word_t   res_data;
  regno_t  res_rd;
  logic    res_wen;
  logic    res_credit;

  // vectors from the data file
  mem_op_t vec_op[$];
  addr_t   vec_addr[$];
  word_t   vec_wdata[$];
  regno_t  vec_rd[$];
  word_t   vec_exp[$];

  // results still owed by the DUT, oldest first
  word_t  exp_data_q[$];
  regno_t exp_rd_q[$];
  logic   exp_wen_q[$];

  logic        loaded;
  logic        reset_done;
  int          results_seen;
  int          credits_back;
  logic [31:0] lcg_state;

  mem_stage_top u_mem_stage_top (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_rd     (req_rd),
    .req_credit (req_credit),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .res_rd     (res_rd),
    .res_wen    (res_wen),
    .res_credit (res_credit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_result(input word_t got_data, input word_t exp_data,
                              input regno_t got_rd, input regno_t exp_rd);
    if (got_data !== exp_data || got_rd !== exp_rd)
      fail_run($sformatf("Mismatch at %0t: data %h rd %0d, expected data %h rd %0d",
                         $time, got_data, got_rd, exp_data, exp_rd));
  endtask

  task automatic check_wen(input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("Mismatch at %0t: res_wen %b, expected %b", $time, got, exp));
  endtask

  task automatic read_vectors();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] op_val;
    addr_t       a;
    word_t       w;
    logic [31:0] rd_val;
    word_t       e;
    fd = $fopen("bench/mem_stage_input.txt", "r");
    if (fd == 0)
      fail_run("could not open the stimulus file bench/mem_stage_input.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0 || line.getc(0) == "#")
        continue;
      cnt = $sscanf(line, "%h %h %h %h %h", op_val, a, w, rd_val, e);
      if (cnt == 5) begin
        vec_op.push_back(mem_op_t'(op_val[3:0]));
        vec_addr.push_back(a);
        vec_wdata.push_back(w);
        vec_rd.push_back(regno_t'(rd_val));
        vec_exp.push_back(e);
      end
    end
    $fclose(fd);
    if (vec_op.size() == 0)
      fail_run("the stimulus file holds no requests");
  endtask

  initial begin : run_main
    reset        = 1'b1;
    req_valid    = 1'b0;
    req_op       = OP_LD;
    req_addr     = '0;
    req_wdata    = '0;
    req_rd       = '0;
    res_credit   = 1'b0;
    loaded       = 1'b0;
    reset_done   = 1'b0;
    results_seen = 0;
    credits_back = 0;
    lcg_state    = 32'h3dcabf0e;
    read_vectors();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    reset_done = 1'b1;
    wait (results_seen == vec_op.size());
    repeat (6) @(posedge clk); // any extra result or credit shows up here
    if (credits_back != vec_op.size()) begin
      fail_run($sformatf("req_credit pulsed %0d times for %0d popped requests",
                         credits_back, vec_op.size()));
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

  // sends one request per cycle while a queue credit is held
  initial begin : drive_requests
    int idx;
    int req_credits;
    idx         = 0;
    req_credits = `MEM_REQ_DEPTH;
    wait (reset_done);
    while (idx < vec_op.size()) begin
      @(posedge clk);
      #1;
      if (req_credit)
        req_credits++;
      if (req_credits > 0) begin
        req_valid = 1'b1;
        req_op    = vec_op[idx];
        req_addr  = vec_addr[idx];
        req_wdata = vec_wdata[idx];
        req_rd    = vec_rd[idx];
        req_credits--;
        exp_data_q.push_back(vec_exp[idx]);
        exp_rd_q.push_back(vec_rd[idx]);
        exp_wen_q.push_back(!(vec_op[idx] inside {OP_SB, OP_SH, OP_SW, OP_SD}));
        idx++;
      end else begin
        req_valid = 1'b0;
      end
    end
    @(posedge clk);
    #1 req_valid = 1'b0;
  end

  // every pop hands one queue credit back
  initial begin : count_credits
    wait (reset_done);
    forever begin
      @(posedge clk);
      #1;
      if (req_credit)
        credits_back++;
    end
  end

  // checks results and hands credits back after a random delay
  initial begin : collect_results
    int          outstanding;
    int          cycle;
    int          due;
    int          last_due;
    int          due_q[$];
    logic [31:0] r;
    outstanding = `MEM_RES_CREDITS;
    cycle       = 0;
    last_due    = 0;
    wait (reset_done);
    forever begin
      @(posedge clk);
      #1;
      cycle++;
      res_credit = 1'b0;
      if (res_valid) begin
        if (outstanding == 0)
          fail_run("res_valid came with no result credit outstanding");
        if (exp_data_q.size() == 0)
          fail_run("a result arrived with no request outstanding");
        check_result(res_data, exp_data_q.pop_front(), res_rd, exp_rd_q.pop_front());
        check_wen(res_wen, exp_wen_q.pop_front());
        outstanding--;
        results_seen++;
        r   = lcg_next();
        due = cycle + int'(r[17:16]); // 0 to 3 cycles
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        due_q.push_back(due);
      end
      if (due_q.size() > 0 && due_q[0] <= cycle) begin
        res_credit = 1'b1;
        void'(due_q.pop_front());
        outstanding++;
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (20 * vec_op.size() + 8) @(posedge clk);
    $display("Timeout: not every result arrived within the allowed cycles");
    $display("Test failures found");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: bench/mem_stage_input.txt
# op(0 lb,1 lbu,2 lh,3 lhu,4 lw,5 lwu,6 ld,7 sb,8 sh,9 sw,a sd) addr wdata rd expected
# all values hex; stores expect zero data
a 100 0123456789abcdef 01 0000000000000000
6 100 0000000000000000 02 0123456789abcdef
a 108 fedcba9876543210 03 0000000000000000
6 108 0000000000000000 04 fedcba9876543210
0 100 0000000000000000 05 ffffffffffffffef
1 100 0000000000000000 06 00000000000000ef
0 107 0000000000000000 07 0000000000000001
1 105 0000000000000000 08 0000000000000045
2 102 0000000000000000 09 ffffffffffff89ab
3 102 0000000000000000 0a 00000000000089ab
2 104 0000000000000000 0b 0000000000004567
4 100 0000000000000000 0c ffffffff89abcdef
5 100 0000000000000000 0d 0000000089abcdef
4 104 0000000000000000 0e 0000000001234567
5 10c 0000000000000000 0f 00000000fedcba98
4 10c 0000000000000000 10 fffffffffedcba98
3 10e 0000000000000000 11 000000000000fedc
0 109 0000000000000000 12 0000000000000032
a 110 0000000000000000 13 0000000000000000
7 110 00000000000000aa 14 0000000000000000
7 117 0000000000000011 15 0000000000000000
8 112 000000000000beef 16 0000000000000000
8 114 0000000000001234 17 0000000000000000
6 110 0000000000000000 18 11001234beef00aa
7 111 ffffffffffffff55 19 0000000000000000
7 116 0000000000000077 1a 0000000000000000
6 110 0000000000000000 1b 11771234beef55aa
a 118 1111111111111111 1c 0000000000000000
9 118 00000000cafebabe 1d 0000000000000000
9 11c 0000000080000001 1e 0000000000000000
6 118 0000000000000000 1f 80000001cafebabe
4 11c 0000000000000000 00 ffffffff80000001
2 113 0000000000000000 01 ffffffffffffbeef
8 118 0000000000007fff 02 0000000000000000
2 118 0000000000000000 03 0000000000007fff
1 11f 0000000000000000 04 0000000000000080
6 100 0000000000000000 05 0123456789abcdef

// File: all.f
+incdir+common
common/mem_data_pkg.sv
common/mem_op_pkg.sv
rtl/req_queue.sv
rtl/mem_issue.sv
dmem/data_ram.sv
dmem/store_merge.sv
rtl/load_align.sv
rtl/mem_stage_top.sv
bench/mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f all.f --top-module mem_stage_tb -o mem_stage_sim \
  && ./obj_dir/mem_stage_sim > sim.log 2>&1 \
  || echo "build or run error" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || grep -q "All tests passed!" sim.log || exit 1
exit 0
